// ==== floorTracker.sv ====
`timescale 1ns/10ps

module floorTracker (
    input  logic                 clock,
    input  logic                 rst,
    input  logic [3:0]           sensors,
    input  logic                 floorInit,
    output smartCargoPkg::floorT currentFloor,
    output logic                 arrivedPulse
);

    logic [3:0]           sensPrev;
    logic [3:0]           rise;
    smartCargoPkg::floorT riseFloor;

    assign rise = sensors & ~sensPrev;

    // lowest rising bit wins
    always_comb begin
        riseFloor = 2'd0;
        casez (rise)
            4'b???1: riseFloor = 2'd0;
            4'b??10: riseFloor = 2'd1;
            4'b?100: riseFloor = 2'd2;
            4'b1000: riseFloor = 2'd3;
            default: riseFloor = 2'd0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            sensPrev     <= '0;
            currentFloor <= '0;
            arrivedPulse <= 1'b0;
        end else begin
            sensPrev     <= sensors;
            arrivedPulse <= |rise;
            if (floorInit) begin
                currentFloor <= '0; // lift parks at ground floor
            end else if (|rise) begin
                currentFloor <= riseFloor;
            end
        end
    end

endmodule

// ==== hexa7seg.sv ====
`timescale 1ns/10ps

module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display  // gfedcba, active low
);

    always_comb begin
        case (hexa)
            4'h0: display = 7'b1000000;
            4'h1: display = 7'b1111001;
            4'h2: display = 7'b0100100;
            4'h3: display = 7'b0110000;
            4'h4: display = 7'b0011001;
            4'h5: display = 7'b0010010;
            4'h6: display = 7'b0000010;
            4'h7: display = 7'b1111000;
            4'h8: display = 7'b0000000;
            4'h9: display = 7'b0010000;
            4'hA: display = 7'b0001000;
            4'hB: display = 7'b0000011;
            4'hC: display = 7'b1000110;
            4'hD: display = 7'b0100001;
            4'hE: display = 7'b0000110;
            default: display = 7'b0001110; // F
        endcase
    end

endmodule

// ==== movementControl.sv ====
`timescale 1ns/10ps

module movementControl #(
    parameter int dwellCycles = 16
) (
    input  logic                     clock,
    input  logic                     rst,
    input  smartCargoPkg::stopEntryT head,
    input  logic                     queueEmpty,
    input  smartCargoPkg::floorT     currentFloor,
    input  logic                     arrivedPulse,
    output logic                     pop,
    output logic                     motorUpReq,
    output logic                     motorDownReq,
    output logic                     loadPulse,
    output logic                     floorInit,
    output logic [3:0]               stateCode
);

    localparam int cntW = (dwellCycles > 1) ? $clog2(dwellCycles) : 1;

    smartCargoPkg::moveStateT state, nextState;
    logic [cntW-1:0]          dwellCnt;
    logic                     dwellDone;
    logic                     arrived;

    assign stateCode    = state;
    assign floorInit    = (state == smartCargoPkg::INIT);
    assign motorUpReq   = (state == smartCargoPkg::UP);
    assign motorDownReq = (state == smartCargoPkg::DOWN);
    assign pop          = (state == smartCargoPkg::POP);

    // floor register only moves together with arrivedPulse
    assign arrived   = arrivedPulse & (currentFloor == head.floor);
    assign dwellDone = (dwellCnt == cntW'(dwellCycles - 1));

    always_comb begin
        nextState = state;
        case (state)
            smartCargoPkg::INIT: begin
                nextState = smartCargoPkg::WAIT;
            end
            smartCargoPkg::WAIT: begin
                if (!queueEmpty) begin
                    if (head.floor > currentFloor) begin
                        nextState = smartCargoPkg::UP;
                    end else if (head.floor < currentFloor) begin
                        nextState = smartCargoPkg::DOWN;
                    end else begin
                        nextState = smartCargoPkg::DWELL; // already there
                    end
                end
            end
            smartCargoPkg::UP, smartCargoPkg::DOWN: begin
                if (arrived) begin
                    nextState = smartCargoPkg::DWELL;
                end
            end
            smartCargoPkg::DWELL: begin
                if (dwellDone) begin
                    nextState = smartCargoPkg::POP;
                end
            end
            smartCargoPkg::POP: begin
                nextState = smartCargoPkg::WAIT;
            end
            default: nextState = smartCargoPkg::INIT;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= smartCargoPkg::INIT;
            loadPulse <= 1'b0;
            dwellCnt  <= '0;
        end else begin
            state <= nextState;
            // one pulse on entry to DWELL, same cycle the motor drops
            loadPulse <= (nextState == smartCargoPkg::DWELL) &&
                         (state != smartCargoPkg::DWELL);
            if (state == smartCargoPkg::DWELL) begin
                dwellCnt <= dwellCnt + 1'b1;
            end else begin
                dwellCnt <= '0;
            end
        end
    end

endmodule

// ==== requestEntry.sv ====
`timescale 1ns/10ps

module requestEntry (
    input  logic                    clock,
    input  logic                    rst,
    input  logic                    reqStrobe,
    input  smartCargoPkg::floorT    reqOrigin,
    input  smartCargoPkg::floorT    reqDest,
    input  logic                    pushGrant,
    output smartCargoPkg::queueReqT push,
    output logic                    reqBusy,
    output logic [3:0]              stateCode
);

    smartCargoPkg::entryStateT state, nextState;
    smartCargoPkg::floorT      originReg, destReg; // latched request

    assign reqBusy   = (state != smartCargoPkg::IDLE);
    assign stateCode = state;

    // request stays up until granted
    always_comb begin
        push.req            = 1'b0;
        push.entry.floor    = originReg;
        push.entry.isOrigin = 1'b1;
        case (state)
            smartCargoPkg::PUSHORIGIN: begin
                push.req = 1'b1;
            end
            smartCargoPkg::PUSHDEST: begin
                push.req            = 1'b1;
                push.entry.floor    = destReg;
                push.entry.isOrigin = 1'b0;
            end
            default: begin
                push.req = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            smartCargoPkg::IDLE: begin
                if (reqStrobe) begin
                    nextState = smartCargoPkg::PUSHORIGIN;
                end
            end
            smartCargoPkg::PUSHORIGIN: begin
                if (pushGrant) begin
                    // same floor twice needs only one stop
                    if (destReg == originReg) begin
                        nextState = smartCargoPkg::IDLE;
                    end else begin
                        nextState = smartCargoPkg::PUSHDEST;
                    end
                end
            end
            smartCargoPkg::PUSHDEST: begin
                if (pushGrant) begin
                    nextState = smartCargoPkg::IDLE;
                end
            end
            default: nextState = smartCargoPkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (state == smartCargoPkg::IDLE && reqStrobe) begin
            originReg <= reqOrigin;
            destReg   <= reqDest;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= smartCargoPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f smartCargo.f --top-module smartCargoTb -o simv
out=$(./obj_dir/simv +verilator+error+limit+1000 || true)
echo "$out"
if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== smartCargo.f ====
smartCargoPkg.sv
hexa7seg.sv
floorTracker.sv
stopQueue.sv
requestEntry.sv
movementControl.sv
smartCargo.sv
smartCargo_assertions.sv
smartCargoTb.sv

// ==== smartCargo.sv ====
`timescale 1ns/10ps

module smartCargo #(
    parameter int queueDepth  = 8,
    parameter int dwellCycles = 16
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 reqStrobe,
    input  smartCargoPkg::floorT reqOrigin,
    input  smartCargoPkg::floorT reqDest,
    input  logic [3:0]           sensors,    // one-hot floor sensors
    input  logic                 emergency,
    output logic                 reqBusy,
    output logic                 motorUp,
    output logic                 motorDown,
    output logic                 loadPulse,
    output logic [6:0]           floorDisplay,
    output logic [6:0]           stopDisplay,
    output logic [6:0]           moveStateDisplay,
    output logic [6:0]           entryStateDisplay
);

    smartCargoPkg::queueReqT  push;
    smartCargoPkg::stopEntryT head;
    smartCargoPkg::floorT     currentFloor;
    logic                     pushGrant, pop, queueEmpty;
    logic                     arrivedPulse, floorInit;
    logic                     motorUpReq, motorDownReq;
    logic [3:0]               moveCode, entryCode;

    // emergency overrides whatever the movement FSM asks for
    assign motorUp   = motorUpReq & ~emergency;
    assign motorDown = motorDownReq & ~emergency;

    requestEntry requestEntryInst (
        .clock     (clock),
        .rst       (rst),
        .reqStrobe (reqStrobe),
        .reqOrigin (reqOrigin),
        .reqDest   (reqDest),
        .pushGrant (pushGrant),
        .push      (push),
        .reqBusy   (reqBusy),
        .stateCode (entryCode)
    );

    movementControl #(.dwellCycles(dwellCycles)) movementControlInst (
        .clock        (clock),
        .rst          (rst),
        .head         (head),
        .queueEmpty   (queueEmpty),
        .currentFloor (currentFloor),
        .arrivedPulse (arrivedPulse),
        .pop          (pop),
        .motorUpReq   (motorUpReq),
        .motorDownReq (motorDownReq),
        .loadPulse    (loadPulse),
        .floorInit    (floorInit),
        .stateCode    (moveCode)
    );

    stopQueue #(.queueDepth(queueDepth)) stopQueueInst (
        .clock      (clock),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .pushGrant  (pushGrant),
        .head       (head),
        .queueEmpty (queueEmpty)
    );

    floorTracker floorTrackerInst (
        .clock        (clock),
        .rst          (rst),
        .sensors      (sensors),
        .floorInit    (floorInit),
        .currentFloor (currentFloor),
        .arrivedPulse (arrivedPulse)
    );

    hexa7seg floorHex (.hexa({2'b00, currentFloor}), .display(floorDisplay));
    hexa7seg stopHex (.hexa({2'b00, head.floor}), .display(stopDisplay));
    hexa7seg moveHex (.hexa(moveCode), .display(moveStateDisplay));
    hexa7seg entryHex (.hexa(entryCode), .display(entryStateDisplay));

endmodule

// ==== smartCargoPkg.sv ====
package smartCargoPkg;

    // floor number, ground floor is 0
    typedef logic [1:0] floorT;

    // one word of the stop memory
    typedef struct packed {
        floorT floor;
        logic  isOrigin; // set for a pickup stop
    } stopEntryT;

    // push request toward the stop queue
    typedef struct packed {
        logic      req;
        stopEntryT entry;
    } queueReqT;

    // request entry FSM, codes go straight to a display digit
    typedef enum logic [3:0] {
        IDLE       = 4'h0,
        PUSHORIGIN = 4'h1,
        PUSHDEST   = 4'h2
    } entryStateT;

    // movement FSM, codes go straight to a display digit
    typedef enum logic [3:0] {
        INIT  = 4'h0,
        WAIT  = 4'h1,
        UP    = 4'h2,
        DOWN  = 4'h3,
        DWELL = 4'h4,
        POP   = 4'h5
    } moveStateT;

endpackage

// ==== smartCargoTb.sv ====
`timescale 1ns/10ps

module smartCargoTb;

    localparam int dwellCycles   = 16;
    localparam int numRequests   = 12;
    localparam int blockRequests = 5;  // one more than a full queue holds
    localparam int holdCycles    = 20;
    // two stops per request, each up to 3 floors of 8 cycles plus a dwell
    localparam int requestCycles = 2 * (3 * 8 + dwellCycles + 4);
    localparam int limitCycles   =
        (numRequests + blockRequests) * requestCycles + holdCycles + 300;

    logic                 clock, rst, reqStrobe, emergency;
    smartCargoPkg::floorT reqOrigin, reqDest;
    logic [3:0]           sensors;
    logic                 reqBusy, motorUp, motorDown, loadPulse;
    logic [6:0]           floorDisplay, stopDisplay, moveStateDisplay, entryStateDisplay;

    smartCargoPkg::floorT expectQ [$]; // stops in push order
    int                   errorCount = 0;
    int                   plantFloor = 0;

    smartCargo #(.queueDepth(8), .dwellCycles(dwellCycles)) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic waitCycle();
        @(posedge clock);
        #1;
    endtask

    // active-low gfedcba pattern
    function automatic logic [6:0] segCode(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic issueRequest(input smartCargoPkg::floorT origin,
                                input smartCargoPkg::floorT dest);
        while (reqBusy) begin
            waitCycle();
        end
        reqStrobe = 1'b1;
        reqOrigin = origin;
        reqDest   = dest;
        expectQ.push_back(origin);
        if (dest != origin) begin
            expectQ.push_back(dest); // equal floors give one stop only
        end
        waitCycle();
        reqStrobe = 1'b0;
    endtask

    task automatic waitDrained();
        while (expectQ.size() != 0 || moveStateDisplay != segCode(4'h1)) begin
            waitCycle(); // until back in WAIT with nothing left
        end
    endtask

    // lift shaft model with one sensor pulse per 6 cycles of drive
    initial begin
        int upCnt;
        int downCnt;
        sensors = 4'b0000;
        upCnt   = 0;
        downCnt = 0;
        forever begin
            @(negedge clock); // motor outputs settled mid-cycle
            upCnt   = motorUp ? upCnt + 1 : 0;
            downCnt = motorDown ? downCnt + 1 : 0;
            waitCycle();
            sensors = 4'b0000;
            if (upCnt == 6 && plantFloor < 3) begin
                plantFloor++;
                sensors = 4'b0001 << plantFloor;
                upCnt   = 0;
            end else if (downCnt == 6 && plantFloor > 0) begin
                plantFloor--;
                sensors = 4'b0001 << plantFloor;
                downCnt = 0;
            end
        end
    end

    initial begin
        smartCargoPkg::floorT expFloor;
        forever begin
            waitCycle();
            if (loadPulse && expectQ.size() == 0) begin
                $display("extra loadPulse with no stop left to serve");
                errorCount++;
            end else if (loadPulse) begin
                expFloor = expectQ.pop_front();
                if (floorDisplay !== segCode({2'b00, expFloor})) begin
                    $display("FAILED displayAtLoad: expected %b, actual %b",
                             segCode({2'b00, expFloor}), floorDisplay);
                    errorCount++;
                end
            end
        end
    end

    initial begin
        #(limitCycles * 4);
        $display("timeout: stops not served within %0d cycles", limitCycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        smartCargoPkg::floorT origin;
        smartCargoPkg::floorT dest;
        int                   assertErrors;
        void'($urandom(6426));
        rst       = 1'b1;
        reqStrobe = 1'b0;
        reqOrigin = '0;
        reqDest   = '0;
        emergency = 1'b0;
        repeat (5) waitCycle();
        rst = 1'b0;
        for (int i = 0; i < numRequests; i++) begin
            origin = 2'($urandom_range(3, 0));
            dest   = (i == 3) ? origin : 2'($urandom_range(3, 0)); // one same-floor request
            issueRequest(origin, dest);
        end
        waitDrained();
        // first stop away from the lift so emergency blocks every pop
        emergency = 1'b1;
        for (int i = 0; i < blockRequests; i++) begin
            origin = (i == 0) ? 2'(plantFloor + 1 + $urandom_range(2, 0))
                              : 2'($urandom_range(3, 0));
            dest   = 2'(origin + 1 + $urandom_range(2, 0));
            issueRequest(origin, dest);
        end
        repeat (holdCycles) waitCycle();
        if (!reqBusy) begin
            $display("reqBusy dropped while the queue was full");
            errorCount++;
        end
        emergency = 1'b0;
        waitDrained();
        assertErrors = dut_i.assertChecks.failCount;
        $display("errors: scoreboard %0d, assertions %0d", errorCount, assertErrors);
        if (errorCount == 0 && assertErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== smartCargo_assertions.sv ====
`timescale 1ns/10ps

module smartCargo_assertions (
    input logic                     clock,
    input logic                     rst,
    input logic                     emergency,
    input logic                     motorUp,
    input logic                     motorDown,
    input logic                     loadPulse,
    input logic                     reqBusy,
    input logic                     queueEmpty,
    input logic                     pushGrant,
    input smartCargoPkg::queueReqT  push,
    input smartCargoPkg::stopEntryT head,
    input smartCargoPkg::floorT     currentFloor,
    input logic [6:0]               floorDisplay,
    input logic [6:0]               stopDisplay,
    input logic [6:0]               moveStateDisplay,
    input logic [6:0]               entryStateDisplay
);

    // digits for IDLE, PUSHORIGIN, PUSHDEST and DWELL
    localparam logic [6:0] segZero = 7'b1000000;
    localparam logic [6:0] segOne  = 7'b1111001;
    localparam logic [6:0] segTwo  = 7'b0100100;
    localparam logic [6:0] segFour = 7'b0011001;

    int failCount = 0; // read by the testbench at the end

    function automatic void recordFailure(input string what);
        $error("%s", what);
        failCount++;
    endfunction

    motorExclusive: assert property (@(posedge clock) disable iff (rst)
        !(motorUp && motorDown)) else recordFailure("both motor outputs high");
    emergencyStop: assert property (@(posedge clock) disable iff (rst)
        emergency |-> !motorUp && !motorDown) else recordFailure("motor ran during emergency");
    // arrival cycle still has the motor on, hence >= and <=
    upDirection: assert property (@(posedge clock) disable iff (rst)
        motorUp |-> !queueEmpty && head.floor >= currentFloor)
        else recordFailure("motorUp without a stop above");
    downDirection: assert property (@(posedge clock) disable iff (rst)
        motorDown |-> !queueEmpty && head.floor <= currentFloor)
        else recordFailure("motorDown without a stop below");
    loadDisplay: assert property (@(posedge clock) disable iff (rst)
        loadPulse |-> floorDisplay == stopDisplay)
        else recordFailure("loadPulse away from the head stop floor");
    loadState: assert property (@(posedge clock) disable iff (rst)
        loadPulse |-> moveStateDisplay == segFour)
        else recordFailure("move state display not DWELL at loadPulse");
    entryState: assert property (@(posedge clock) disable iff (rst)
        entryStateDisplay == (!reqBusy ? segZero :
                              (push.entry.isOrigin ? segOne : segTwo)))
        else recordFailure("entry state display disagrees with the pending push");
    busyHeld: assert property (@(posedge clock) disable iff (rst)
        push.req && !pushGrant |=> reqBusy) else recordFailure("reqBusy fell on a stalled push");
    resetQuiet: assert property (@(posedge clock)
        rst |=> !motorUp && !motorDown && !loadPulse && !reqBusy)
        else recordFailure("outputs active right after reset");

endmodule

bind smartCargo smartCargo_assertions assertChecks (.*);

// ==== stopQueue.sv ====
`timescale 1ns/10ps

module stopQueue #(
    parameter int queueDepth = 8
) (
    input  logic                     clock,
    input  logic                     rst,
    input  smartCargoPkg::queueReqT  push,
    input  logic                     pop,
    output logic                     pushGrant,
    output smartCargoPkg::stopEntryT head,
    output logic                     queueEmpty
);

    localparam int addrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW  = $clog2(queueDepth + 1);

    smartCargoPkg::stopEntryT mem [queueDepth];

    logic [addrW-1:0] rdPtr, wrPtr;
    logic [cntW-1:0]  count;
    logic             queueFull;
    logic             popGrant;

    // pointer advance with wrap for any depth
    function automatic logic [addrW-1:0] nextPtr(input logic [addrW-1:0] ptr);
        logic [addrW-1:0] result;
        if (ptr == addrW'(queueDepth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign queueEmpty = (count == '0);
    assign queueFull  = (count == cntW'(queueDepth));

    // fixed priority, pop wins over push
    assign popGrant  = pop & ~queueEmpty;
    assign pushGrant = push.req & ~pop & ~queueFull;

    assign head = mem[rdPtr]; // oldest stop

    always_ff @(posedge clock) begin
        if (pushGrant) begin
            mem[wrPtr] <= push.entry;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (pushGrant) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popGrant) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushGrant, popGrant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // grants never overlap
            endcase
        end
    end

endmodule
